// ==== design/mul_macros.svh ====
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// Request tag width
`define MUL_TAG_W 4

// Result buffer entries, 2, 4 or 8
`define RESULT_FIFO_DEPTH 4

// Register stages in the multiplier
`define MUL_STAGES 2

// Width of an occupancy or free-slot count
`define RESULT_FIFO_CNT_W ($clog2(`RESULT_FIFO_DEPTH + 1))

`endif

// ==== design/mul_pkg.sv ====
`include "mul_macros.svh"

package mul_pkg;

    // Operand seen as a full word or as byte lanes
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;  // lanes[0] is the low byte
    } operand_t;

    typedef struct packed {
        logic                  valid;  // One-cycle strobe
        logic [`MUL_TAG_W-1:0] tag;
        operand_t              a;
        operand_t              b;
    } mul_req_t;

    typedef struct packed {
        logic                  valid;
        logic [`MUL_TAG_W-1:0] tag;
        logic [31:0]           product;  // Low half of a * b
    } mul_rsp_t;

endpackage

// ==== design/wallace_mul8.sv ====
module wallace_mul8 (
    input  logic [7:0]  a,
    input  logic [7:0]  b,
    output logic [15:0] product
);

    wire [7:0]  p [8];  // p[i][j] has weight i + j
    wire [53:1] s;
    wire [63:1] c;

    // Returns {carry, sum}
    function automatic logic [1:0] fa(input logic x, input logic y, input logic z);
        logic t;
        t = x ^ y;
        return {(x & y) | (z & t), z ^ t};
    endfunction

    function automatic logic [1:0] ha(input logic x, input logic y);
        return {x & y, x ^ y};
    endfunction

    for (genvar i = 0; i < 8; i++) begin : g_pp
        assign p[i] = a & {8{b[i]}};
    end

    // Layer 1, rows 0-2 and rows 3-5
    assign {c[1], s[1]}   = ha(p[0][1], p[1][0]);
    assign {c[2], s[2]}   = fa(p[0][2], p[1][1], p[2][0]);
    assign {c[3], s[3]}   = fa(p[0][3], p[1][2], p[2][1]);
    assign {c[4], s[4]}   = fa(p[0][4], p[1][3], p[2][2]);
    assign {c[10], s[10]} = ha(p[3][1], p[4][0]);
    assign {c[5], s[5]}   = fa(p[0][5], p[1][4], p[2][3]);
    assign {c[11], s[11]} = fa(p[3][2], p[4][1], p[5][0]);
    assign {c[6], s[6]}   = fa(p[0][6], p[1][5], p[2][4]);
    assign {c[12], s[12]} = fa(p[3][3], p[4][2], p[5][1]);
    assign {c[7], s[7]}   = fa(p[0][7], p[1][6], p[2][5]);
    assign {c[13], s[13]} = fa(p[3][4], p[4][3], p[5][2]);
    assign {c[8], s[8]}   = ha(p[1][7], p[2][6]);
    assign {c[14], s[14]} = fa(p[3][5], p[4][4], p[5][3]);
    assign {c[9], s[9]}   = fa(p[2][7], p[3][6], p[4][5]);
    assign {c[15], s[15]} = fa(p[3][7], p[4][6], p[5][5]);
    assign {c[16], s[16]} = ha(p[4][7], p[5][6]);

    // Layer 2, rows 6-7 join here
    assign {c[17], s[17]} = ha(s[2], c[1]);
    assign {c[18], s[18]} = fa(s[3], c[2], p[3][0]);
    assign {c[19], s[19]} = fa(s[4], c[3], s[10]);
    assign {c[20], s[20]} = fa(s[5], c[4], s[11]);
    assign {c[21], s[21]} = fa(s[6], c[5], s[12]);
    assign {c[22], s[22]} = fa(s[7], c[6], s[13]);
    assign {c[23], s[23]} = fa(s[8], c[7], s[14]);
    assign {c[24], s[24]} = fa(s[9], c[8], c[14]);
    assign {c[29], s[29]} = fa(c[9], p[6][4], p[7][3]);
    assign {c[30], s[30]} = fa(c[15], p[6][5], p[7][4]);
    assign {c[31], s[31]} = fa(p[5][7], p[6][6], p[7][5]);
    assign {c[32], s[32]} = ha(p[6][7], p[7][6]);
    assign {c[25], s[25]} = ha(p[6][0], c[11]);
    assign {c[26], s[26]} = fa(c[12], p[6][1], p[7][0]);
    assign {c[27], s[27]} = fa(c[13], p[6][2], p[7][1]);
    assign {c[28], s[28]} = fa(p[5][4], p[6][3], p[7][2]);

    // Layer 3
    assign {c[33], s[33]} = ha(s[18], c[17]);
    assign {c[34], s[34]} = ha(s[19], c[18]);
    assign {c[35], s[35]} = fa(s[20], c[19], c[10]);
    assign {c[36], s[36]} = fa(s[21], c[20], s[25]);
    assign {c[37], s[37]} = fa(s[22], c[21], s[26]);
    assign {c[38], s[38]} = fa(s[23], c[22], s[27]);
    assign {c[39], s[39]} = fa(s[24], c[23], s[28]);
    assign {c[40], s[40]} = fa(s[15], c[24], s[29]);
    assign {c[41], s[41]} = ha(s[16], s[30]);
    assign {c[42], s[42]} = ha(c[16], s[31]);

    // Layer 4, two rows left afterwards
    assign {c[43], s[43]} = ha(s[34], c[33]);
    assign {c[44], s[44]} = ha(s[35], c[34]);
    assign {c[45], s[45]} = ha(s[36], c[35]);
    assign {c[46], s[46]} = fa(s[37], c[36], c[25]);
    assign {c[47], s[47]} = fa(s[38], c[37], c[26]);
    assign {c[48], s[48]} = fa(s[39], c[38], c[27]);
    assign {c[49], s[49]} = fa(s[40], c[39], c[28]);
    assign {c[50], s[50]} = fa(s[41], c[40], c[29]);
    assign {c[51], s[51]} = fa(s[42], c[30], c[41]);
    assign {c[52], s[52]} = fa(c[42], s[32], c[31]);
    assign {c[53], s[53]} = ha(p[7][7], c[32]);

    // Final ripple from bit 5
    assign product[0] = p[0][0];
    assign product[1] = s[1];
    assign product[2] = s[17];
    assign product[3] = s[33];
    assign product[4] = s[43];
    assign {c[54], product[5]}  = ha(s[44], c[43]);
    assign {c[55], product[6]}  = fa(s[45], c[44], c[54]);
    assign {c[56], product[7]}  = fa(s[46], c[45], c[55]);
    assign {c[57], product[8]}  = fa(s[47], c[46], c[56]);
    assign {c[58], product[9]}  = fa(s[48], c[47], c[57]);
    assign {c[59], product[10]} = fa(s[49], c[48], c[58]);
    assign {c[60], product[11]} = fa(s[50], c[49], c[59]);
    assign {c[61], product[12]} = fa(s[51], c[50], c[60]);
    assign {c[62], product[13]} = fa(s[52], c[51], c[61]);
    assign {c[63], product[14]} = fa(s[53], c[52], c[62]);
    assign product[15] = c[53] | c[63];  // At most one is set, product < 2**16

endmodule

// ==== design/mul_unit.sv ====
`include "mul_macros.svh"

module mul_unit import mul_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  mul_req_t                       req,
    input  logic [`RESULT_FIFO_CNT_W-1:0] free_slots,
    output logic                           busy,
    output logic                           reject,
    output mul_rsp_t                       prod
);

    localparam int NPROD    = 10;  // Lane pairs with i + j <= 3
    localparam int CNT_W    = `RESULT_FIFO_CNT_W;
    localparam int FLIGHT_W = $clog2(`MUL_STAGES + 1);

    logic                  accept;
    logic [FLIGHT_W-1:0]   in_flight;
    logic [15:0]           byte_prod [NPROD];
    logic [31:0]           term [NPROD];
    logic [31:0]           sum;

    logic                  s1_valid;
    logic [`MUL_TAG_W-1:0] s1_tag;
    logic [15:0]           s1_prod [NPROD];

    logic                  s2_valid;
    logic [`MUL_TAG_W-1:0] s2_tag;
    logic [31:0]           s2_product;

    // New request also needs a slot, so equality already blocks
    assign busy   = free_slots <= CNT_W'(in_flight);
    assign accept = req.valid && !busy;

    for (genvar i = 0; i < 4; i++) begin : g_lane_a
        for (genvar j = 0; j < 4 - i; j++) begin : g_lane_b
            localparam int K = 4 * i - i * (i - 1) / 2 + j;

            wallace_mul8 i_wallace_mul8 (
                .a       (req.a.lanes[i]),
                .b       (req.b.lanes[j]),
                .product (byte_prod[K])
            );

            assign term[K] = {16'b0, s1_prod[K]} << (8 * (i + j));  // Top bits fall off
        end
    end

    always_comb begin
        sum = '0;
        for (int k = 0; k < NPROD; k++) begin
            sum = sum + term[k];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            in_flight <= '0;
            reject    <= 1'b0;
        end else begin
            s1_valid  <= accept;
            s2_valid  <= s1_valid;
            in_flight <= in_flight + FLIGHT_W'(accept) - FLIGHT_W'(s2_valid);
            reject    <= req.valid && busy;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_tag  <= req.tag;
            s1_prod <= byte_prod;
        end
        if (s1_valid) begin
            s2_tag     <= s1_tag;
            s2_product <= sum;
        end
    end

    assign prod = '{valid: s2_valid, tag: s2_tag, product: s2_product};

    a_push_has_room: assert property (@(posedge clk) disable iff (!rst_n)
        prod.valid |-> free_slots != '0)
        else $error("mul_unit: result pushed with no free slot");

    // Byte-lane sum against the full word product
    a_low_product: assert property (@(posedge clk) disable iff (!rst_n)
        prod.valid |-> prod.product == $past(req.a.word * req.b.word, 2))
        else $error("mul_unit: low product mismatch");

endmodule

// ==== design/result_fifo.sv ====
`include "mul_macros.svh"

module result_fifo import mul_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  mul_rsp_t                       push_data,
    input  logic                           pop,
    output mul_rsp_t                       head,
    output logic [`RESULT_FIFO_CNT_W-1:0] free_slots
);

    localparam int DEPTH = `RESULT_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = `RESULT_FIFO_CNT_W;

    logic                  push;
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic [`MUL_TAG_W-1:0] tag_mem [DEPTH];
    logic [31:0]           prod_mem [DEPTH];

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push = push_data.valid;

    always_ff @(posedge clk) begin
        if (push) begin
            tag_mem[wr_ptr]  <= push_data.tag;
            prod_mem[wr_ptr] <= push_data.product;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    assign free_slots = CNT_W'(DEPTH) - count;

    // Head shows as soon as it is written
    assign head = '{valid: count != '0, tag: tag_mem[rd_ptr], product: prod_mem[rd_ptr]};

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> count != CNT_W'(DEPTH))
        else $error("result_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> count != '0)
        else $error("result_fifo: pop while empty");

endmodule

// ==== design/result_writeback.sv ====
`include "mul_macros.svh"

module result_writeback import mul_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_en,
    input  mul_rsp_t    head,
    output logic        pop,
    output mul_rsp_t    rsp,
    output logic [15:0] retired_count
);

    logic                  rsp_valid;
    logic [`MUL_TAG_W-1:0] rsp_tag;
    logic [31:0]           rsp_product;

    assign pop = wb_en && head.valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid     <= 1'b0;
            retired_count <= '0;
        end else begin
            rsp_valid <= pop;
            if (pop) begin
                retired_count <= retired_count + 16'd1;  // Wraps
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rsp_tag     <= head.tag;
            rsp_product <= head.product;
        end
    end

    assign rsp = '{valid: rsp_valid, tag: rsp_tag, product: rsp_product};

    // Back-to-back results only from back-to-back pops
    a_valid_from_pop: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.valid && $past(rsp.valid)) |-> ($past(pop) && $past(pop, 2)))
        else $error("result_writeback: response without a matching pop");

endmodule

// ==== design/mul_cluster.sv ====
`include "mul_macros.svh"

module mul_cluster import mul_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  mul_req_t    req,
    input  logic        wb_en,
    output mul_rsp_t    rsp,
    output logic        busy,
    output logic        reject,
    output logic [15:0] retired_count
);

    mul_rsp_t                       prod;
    mul_rsp_t                       head;
    logic                           pop;
    logic [`RESULT_FIFO_CNT_W-1:0] free_slots;

    mul_unit i_mul_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .free_slots (free_slots),
        .busy       (busy),
        .reject     (reject),
        .prod       (prod)
    );

    result_fifo i_result_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_data  (prod),
        .pop        (pop),
        .head       (head),
        .free_slots (free_slots)
    );

    result_writeback i_result_writeback (
        .clk           (clk),
        .rst_n         (rst_n),
        .wb_en         (wb_en),
        .head          (head),
        .pop           (pop),
        .rsp           (rsp),
        .retired_count (retired_count)
    );

endmodule

// ==== testbench/tb_mul_cluster.sv ====
`include "mul_macros.svh"

module tb_mul_cluster import mul_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LATENCY = `MUL_STAGES + 1;  // Empty buffer with wb_en high
    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic [`MUL_TAG_W-1:0] tag;
        logic [31:0]           product;
        logic [31:0]           edge_no;  // Accepting clock edge
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n;
    mul_req_t    req;
    logic        wb_en;
    mul_rsp_t    rsp;
    logic        busy;
    logic        reject;
    logic [15:0] retired_count;

    expect_t               model_q [$];
    logic [31:0]           lfsr = 32'h3d0f;
    logic [`MUL_TAG_W-1:0] next_tag = '0;
    int unsigned           cyc = 0;
    int                    errors = 0;
    int                    checks = 0;
    int                    tests = 0;
    int                    rsp_seen = 0;
    int                    reject_seen = 0;
    logic                  exp_reject = 1'b0;
    logic                  check_latency = 1'b0;

    mul_cluster i_mul_cluster (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .wb_en         (wb_en),
        .rsp           (rsp),
        .busy          (busy),
        .reject        (reject),
        .retired_count (retired_count)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[31]};
        end
    endtask

    function automatic logic [31:0] low_product(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] full;
        full = {32'b0, a} * {32'b0, b};
        return full[31:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    // Outputs are stable at the falling edge
    task automatic observe();
        expect_t e;
        if (rsp.valid) begin
            rsp_seen++;
            if (model_q.size() == 0) begin
                check_true(1'b0, "response arrived with no request outstanding");
            end else begin
                e = model_q.pop_front();
                check_value("rsp.tag", 32'(rsp.tag), 32'(e.tag));
                check_value("rsp.product", rsp.product, e.product);
                if (check_latency) begin
                    check_value("rsp latency", cyc - e.edge_no, LATENCY);
                end
            end
        end
        if (reject) begin
            reject_seen++;
        end
        check_value("reject", 32'(reject), 32'(exp_reject));
        exp_reject = 1'b0;
    endtask

    task automatic tick();
        @(negedge clk);
        observe();
        req.valid = 1'b0;  // Strobe lasts one cycle
    endtask

    task automatic send(input logic [31:0] a, input logic [31:0] b, output logic accepted);
        expect_t e;
        req.valid  = 1'b1;
        req.tag    = next_tag;
        req.a.word = a;
        req.b.word = b;
        accepted   = !busy;
        if (accepted) begin
            e.tag     = next_tag;
            e.product = low_product(a, b);
            e.edge_no = cyc + 1;
            model_q.push_back(e);
            next_tag = next_tag + 1'b1;
        end else begin
            exp_reject = 1'b1;
        end
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (model_q.size() != 0 && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (model_q.size() != 0) begin
            check_true(1'b0, {"timeout waiting for ", what, " results to drain"});
        end
    endtask

    task automatic finish_test(input string name, input int start);
        tests++;
        $display("%-20s done, %0d errors", name, errors - start);
    endtask

    task automatic test_directed();
        logic [31:0] ops [14];
        logic        ok;
        int          start;
        start = errors;
        ops = '{32'h0000_0000, 32'h1234_5678,  32'h0000_0001, 32'h0000_0001,
                32'hffff_ffff, 32'hffff_ffff,  32'h8000_0000, 32'h0000_0002,
                32'h0000_00ff, 32'h0000_00ff,  32'hffff_ffff, 32'h0000_ffff,
                32'hdead_beef, 32'h1357_9bdf};
        tick();
        wb_en = 1'b1;
        check_latency = 1'b1;
        for (int k = 0; k < 7; k++) begin
            tick();
            send(ops[2 * k], ops[2 * k + 1], ok);
            check_true(ok, "directed request was refused");
            wait_drained("directed");
            tick();
        end
        check_latency = 1'b0;
        finish_test("directed_products", start);
    endtask

    task automatic test_random_stream();
        logic [31:0] a;
        logic [31:0] b;
        logic        ok;
        int          start;
        start = errors;
        tick();
        wb_en = 1'b1;
        for (int k = 0; k < 40; k++) begin
            tick();
            random_word(a);
            random_word(b);
            send(a, b, ok);
        end
        wait_drained("random stream");
        finish_test("random_stream", start);
    endtask

    task automatic test_backpressure();
        logic [31:0] a;
        logic [31:0] b;
        logic        ok;
        int          start;
        int          sent;
        int          accepted;
        start = errors;
        sent = 0;
        accepted = 0;
        tick();
        wb_en = 1'b0;
        reject_seen = 0;
        for (int k = 0; k < 12; k++) begin
            tick();
            random_word(a);
            random_word(b);
            send(a, b, ok);
            sent++;
            if (ok) begin
                accepted++;
            end
        end
        for (int k = 0; k < 6; k++) begin
            tick();
            check_value("rsp.valid", 32'(rsp.valid), 32'd0);
        end
        check_true(accepted > 0, "no request was accepted with the buffer empty");
        check_true(accepted <= `RESULT_FIFO_DEPTH, "more requests accepted than buffer entries");
        check_value("reject pulses", reject_seen, sent - accepted);
        wb_en = 1'b1;
        wait_drained("buffered");
        finish_test("backpressure", start);
    endtask

    task automatic test_retired_count();
        int start;
        start = errors;
        tick();
        check_value("retired_count", 32'(retired_count), rsp_seen);
        finish_test("retired_count", start);
    endtask

    task automatic test_reset_in_flight();
        logic [31:0] a;
        logic [31:0] b;
        logic        ok;
        int          start;
        start = errors;
        tick();
        wb_en = 1'b0;
        for (int k = 0; k < `RESULT_FIFO_DEPTH; k++) begin
            tick();
            random_word(a);
            random_word(b);
            send(a, b, ok);
        end
        repeat (4) tick();
        check_value("busy", 32'(busy), 32'd1);  // Buffer full
        rst_n = 1'b0;
        model_q.delete();  // Buffered results are lost by design
        exp_reject = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        rsp_seen = 0;
        for (int k = 0; k < 5; k++) begin
            tick();
            check_value("rsp.valid", 32'(rsp.valid), 32'd0);
            check_value("busy", 32'(busy), 32'd0);
            check_value("retired_count", 32'(retired_count), 32'd0);
        end
        wb_en = 1'b1;
        for (int k = 0; k < 8; k++) begin
            tick();
            check_value("rsp.valid", 32'(rsp.valid), 32'd0);
        end
        for (int k = 0; k < 2; k++) begin
            tick();
            random_word(a);
            random_word(b);
            send(a, b, ok);
            check_true(ok, "request refused after reset");
        end
        wait_drained("post-reset");
        finish_test("reset_in_flight", start);
    endtask

    initial begin
        rst_n = 1'b0;
        req   = '0;
        wb_en = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        test_directed();
        test_random_stream();
        test_backpressure();
        test_retired_count();
        test_reset_in_flight();
        test_retired_count();
        tick();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+design
design/mul_pkg.sv
design/wallace_mul8.sv
design/mul_unit.sv
design/result_fifo.sv
design/result_writeback.sv
design/mul_cluster.sv
testbench/tb_mul_cluster.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mul_cluster
RTL_TOP   ?= mul_cluster
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Result: PASSED
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
